//--- sources.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/mem_if.sv
rtl/alu.sv
rtl/exu_next_pc.sv
rtl/exu.sv
rtl/data_mem.sv
rtl/exec_top.sv
sim/exec_chk.sv
sim/tb_exec.sv

//--- sim/tb_exec.sv
`timescale 1ns/100ps
`include "exec_defs.svh"

module tb_exec;
  import exec_pkg::*;

  typedef struct packed {
    opcode_e opcode;
    logic [2:0] funct;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN_W-1:0] pc;
    logic [`XLEN_W-1:0] src1;
    logic [`XLEN_W-1:0] src2;
    logic [`XLEN_W-1:0] imm;
    logic [`XLEN_W-1:0] csr;
    logic [`XLEN_W-1:0] alu_a;
    logic [`XLEN_W-1:0] alu_b;
    alu_funct_e alu_funct;
    logic alu_funcs;
    logic [`XLEN_W-1:0] exp_npc;
    logic exp_wen;
    logic [`XLEN_W-1:0] exp_wdata; // alu, csr or load result
    logic exp_csr1;
    logic [`CSR_ADDR_W-1:0] exp_csr1_addr;
    logic [`XLEN_W-1:0] exp_csr1_data;
    logic exp_csr2;
  } entry_t;

  logic clk;
  logic rstn;
  logic id_valid;
  logic id_ready;
  logic [`XLEN_W-1:0] pc;
  opcode_e opcode;
  logic [2:0] funct;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`XLEN_W-1:0] src1;
  logic [`XLEN_W-1:0] src2;
  logic [`XLEN_W-1:0] imm;
  logic [`XLEN_W-1:0] csr;
  logic [`XLEN_W-1:0] alu_a;
  logic [`XLEN_W-1:0] alu_b;
  alu_funct_e alu_funct;
  logic alu_funcs;
  logic [`XLEN_W-1:0] npc;
  logic gpr_wen;
  logic [`REG_ADDR_W-1:0] gpr_waddr;
  logic [`XLEN_W-1:0] gpr_wdata;
  logic csr_wen1;
  logic [`CSR_ADDR_W-1:0] csr_waddr1;
  logic [`XLEN_W-1:0] csr_wdata1;
  logic csr_wen2;
  logic [`CSR_ADDR_W-1:0] csr_waddr2;
  logic [`XLEN_W-1:0] csr_wdata2;

  entry_t table_q[$];
  string name_q[$];
  logic [7:0] mem_model [int]; // byte-addressed view of the data memory
  logic [`XLEN_W-1:0] cur_pc = 32'h1000;
  int err_cnt = 0;
  int cycles = 0;
  int timeout_cycles = 0;

  exec_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (timeout_cycles > 0 && cycles > timeout_cycles) begin
      $display("timeout: no finish within %0d cycles", timeout_cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [`XLEN_W-1:0] ref_alu(input logic [`XLEN_W-1:0] a,
                                                 input logic [`XLEN_W-1:0] b,
                                                 input alu_funct_e f, input logic s);
    case (f)
      ADD:  return s ? a - b : a + b;
      SLL:  return a << b[4:0];
      SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLTU: return (a < b) ? 32'd1 : 32'd0;
      XOR:  return a ^ b;
      SR:   return s ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  // branch outcome from the operands themselves, not from the alu value
  function automatic logic [`XLEN_W-1:0] ref_npc(input entry_t e);
    logic taken;
    logic [`XLEN_W-1:0] t;
    case (branch_e'(e.funct))
      BR_BEQ:  taken = (e.src1 == e.src2);
      BR_BNE:  taken = (e.src1 != e.src2);
      BR_BLT:  taken = ($signed(e.src1) < $signed(e.src2));
      BR_BGE:  taken = ($signed(e.src1) >= $signed(e.src2));
      BR_BLTU: taken = (e.src1 < e.src2);
      default: taken = (e.src1 >= e.src2);
    endcase
    case (e.opcode)
      OP_JAL:    t = e.pc + e.imm;
      OP_JALR:   t = e.src1 + e.imm;
      OP_BRANCH: t = taken ? e.pc + e.imm : e.pc + 4;
      OP_SYS:    t = (e.funct == 3'd0) ? e.csr : e.pc + 4;
      default:   t = e.pc + 4;
    endcase
    return t & ~32'd1;
  endfunction

  function automatic int size_bytes(input mem_size_e sz);
    case (sz)
      MS_B, MS_BU: return 1;
      MS_H, MS_HU: return 2;
      default:     return 4;
    endcase
  endfunction

  function automatic void model_store(input logic [`XLEN_W-1:0] addr, input mem_size_e sz,
                                      input logic [`XLEN_W-1:0] data);
    for (int k = 0; k < size_bytes(sz); k++) mem_model[addr + k] = data[8*k +: 8];
  endfunction

  function automatic logic [`XLEN_W-1:0] model_load(input logic [`XLEN_W-1:0] addr,
                                                    input mem_size_e sz);
    logic [`XLEN_W-1:0] w;
    w = '0;
    for (int k = 0; k < size_bytes(sz); k++) w[8*k +: 8] = mem_model[addr + k];
    if (sz == MS_B) w = {{24{w[7]}}, w[7:0]}; // sign extend
    if (sz == MS_H) w = {{16{w[15]}}, w[15:0]};
    return w;
  endfunction

  task automatic add_op(input string name, input opcode_e op, input logic [2:0] fn,
                        input logic [`REG_ADDR_W-1:0] rd_i, input logic [`XLEN_W-1:0] pc_i,
                        input logic [`XLEN_W-1:0] s1, input logic [`XLEN_W-1:0] s2,
                        input logic [`XLEN_W-1:0] imm_i, input logic [`XLEN_W-1:0] csr_i,
                        input logic [`XLEN_W-1:0] a, input logic [`XLEN_W-1:0] b,
                        input alu_funct_e af, input logic fs);
    entry_t e;
    logic [`XLEN_W-1:0] alu_v;
    e = '0;
    e.opcode = op;
    e.funct = fn;
    e.rd = rd_i;
    e.pc = pc_i;
    e.src1 = s1;
    e.src2 = s2;
    e.imm = imm_i;
    e.csr = csr_i;
    e.alu_a = a;
    e.alu_b = b;
    e.alu_funct = af;
    e.alu_funcs = fs;
    alu_v = ref_alu(a, b, af, fs);
    e.exp_npc = ref_npc(e);
    case (op)
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_CALRI, OP_CALRR: begin
        e.exp_wen = 1'b1;
        e.exp_wdata = alu_v;
      end
      OP_STORE: model_store(alu_v, mem_size_e'(fn), s2);
      OP_LOAD: begin
        e.exp_wen = 1'b1;
        e.exp_wdata = model_load(alu_v, mem_size_e'(fn));
      end
      OP_SYS: begin
        if (fn != 3'd0) begin // csr access
          e.exp_wen = 1'b1;
          e.exp_wdata = csr_i;
          e.exp_csr1 = 1'b1;
          e.exp_csr1_addr = imm_i[`CSR_ADDR_W-1:0];
          e.exp_csr1_data = alu_v;
        end else if (imm_i[`CSR_ADDR_W-1:0] == '0) begin // ecall
          e.exp_csr1 = 1'b1;
          e.exp_csr1_addr = `CSR_MEPC;
          e.exp_csr1_data = alu_v;
          e.exp_csr2 = 1'b1;
        end
      end
      default: ;
    endcase
    table_q.push_back(e);
    name_q.push_back(name);
  endtask

  task automatic add_alu(input string name, input alu_funct_e af, input logic fs,
                         input logic [`XLEN_W-1:0] a, input logic [`XLEN_W-1:0] b);
    add_op(name, OP_CALRR, af, 5'(table_q.size() % 31 + 1), cur_pc, a, b, '0, '0,
           a, b, af, fs);
    cur_pc += 4;
  endtask

  task automatic add_branch(input string name, input branch_e br,
                            input logic [`XLEN_W-1:0] s1, input logic [`XLEN_W-1:0] s2);
    alu_funct_e af;
    logic fs;
    af = (br == BR_BEQ || br == BR_BNE) ? ADD : (br == BR_BLT || br == BR_BGE) ? SLT : SLTU;
    fs = (af == ADD); // subtract for eq/ne
    add_op(name, OP_BRANCH, br, '0, cur_pc, s1, s2, 32'hFFFF_FFF0, '0, s1, s2, af, fs);
    cur_pc += 4;
  endtask

  task automatic add_mem(input string name, input opcode_e op, input mem_size_e sz,
                         input logic [`XLEN_W-1:0] base, input logic [`XLEN_W-1:0] off,
                         input logic [`XLEN_W-1:0] data, input logic [`REG_ADDR_W-1:0] rd_i);
    add_op(name, op, sz, rd_i, cur_pc, base, data, off, '0, base, off, ADD, 1'b0);
    cur_pc += 4;
  endtask

  task automatic build_table();
    add_alu("add", ADD, 1'b0, 32'd5, 32'd7);
    add_alu("sub", ADD, 1'b1, 32'd5, 32'd7);
    add_alu("sll", SLL, 1'b0, 32'h8000_0001, 32'd4);
    add_alu("slt", SLT, 1'b0, 32'hFFFF_FFFE, 32'd1);
    add_alu("sltu", SLTU, 1'b0, 32'hFFFF_FFFE, 32'd1);
    add_alu("xor", XOR, 1'b0, 32'hF0F0_F0F0, 32'h0FF0_0FF0);
    add_alu("srl", SR, 1'b0, 32'h8000_0000, 32'd3);
    add_alu("sra", SR, 1'b1, 32'h8000_0000, 32'd3);
    add_alu("or", OR, 1'b0, 32'h00FF_0000, 32'h0000_FF00);
    add_alu("and", AND, 1'b0, 32'h1234_5678, 32'h0F0F_0F0F);
    add_op("lui", OP_LUI, 3'd0, 5'd3, 32'h2000, '0, '0, 32'h1234_5000, '0,
           '0, 32'h1234_5000, ADD, 1'b0);
    add_op("auipc", OP_AUIPC, 3'd0, 5'd4, 32'h2004, '0, '0, 32'h3000, '0,
           32'h2004, 32'h3000, ADD, 1'b0);
    add_op("jal", OP_JAL, 3'd0, 5'd1, 32'h2100, '0, '0, 32'h40, '0,
           32'h2100, 32'd4, ADD, 1'b0);
    add_op("jalr_odd", OP_JALR, 3'd0, 5'd1, 32'h2200, 32'h3001, '0, 32'h10, '0,
           32'h2200, 32'd4, ADD, 1'b0);
    add_branch("beq_taken", BR_BEQ, 32'd5, 32'd5);
    add_branch("beq_not", BR_BEQ, 32'd5, 32'd6);
    add_branch("bne_taken", BR_BNE, 32'd5, 32'd6);
    add_branch("bne_not", BR_BNE, 32'd5, 32'd5);
    add_branch("blt_taken", BR_BLT, 32'hFFFF_FFFF, 32'd1);
    add_branch("blt_not", BR_BLT, 32'd1, 32'hFFFF_FFFF);
    add_branch("bge_taken", BR_BGE, 32'd1, 32'hFFFF_FFFF);
    add_branch("bge_not", BR_BGE, 32'hFFFF_FFFF, 32'd1);
    add_branch("bltu_taken", BR_BLTU, 32'd1, 32'hFFFF_FFFF);
    add_branch("bltu_not", BR_BLTU, 32'hFFFF_FFFF, 32'd1);
    add_branch("bgeu_taken", BR_BGEU, 32'hFFFF_FFFF, 32'd1);
    add_branch("bgeu_not", BR_BGEU, 32'd1, 32'hFFFF_FFFF);
    add_mem("sw", OP_STORE, MS_W, 32'hF0, 32'h10, 32'h1234_5678, '0);
    add_mem("lw", OP_LOAD, MS_W, 32'hF0, 32'h10, '0, 5'd5);
    add_mem("sb", OP_STORE, MS_B, 32'h100, 32'd1, 32'hFFFF_FFA5, '0);
    add_mem("lb", OP_LOAD, MS_B, 32'h100, 32'd1, '0, 5'd6);
    add_mem("lbu", OP_LOAD, MS_BU, 32'h100, 32'd1, '0, 5'd7);
    add_mem("lw_after_sb", OP_LOAD, MS_W, 32'h100, 32'd0, '0, 5'd8);
    add_mem("sh", OP_STORE, MS_H, 32'h100, 32'd2, 32'h0000_8001, '0);
    add_mem("lh", OP_LOAD, MS_H, 32'h100, 32'd2, '0, 5'd9);
    add_mem("lhu", OP_LOAD, MS_HU, 32'h100, 32'd2, '0, 5'd10);
    add_mem("lw_after_sh", OP_LOAD, MS_W, 32'h100, 32'd0, '0, 5'd11);
    // csrrw to 0x300, then ecall and mret
    add_op("csrrw", OP_SYS, 3'd1, 5'd12, 32'h5000, 32'hABCD, '0, 32'h300, 32'h1800,
           32'hABCD, '0, ADD, 1'b0);
    add_op("ecall", OP_SYS, 3'd0, '0, 32'h5004, '0, '0, '0, 32'h8000_0100,
           32'h5004, '0, ADD, 1'b0);
    add_op("mret", OP_SYS, 3'd0, '0, 32'h8000_0180, '0, '0, 32'h302, 32'h5008,
           '0, '0, ADD, 1'b0);
    add_alu("mix_add", ADD, 1'b0, 32'h7FFF_FFFF, 32'd1);
    add_mem("mix_sw", OP_STORE, MS_W, 32'h200, 32'd0, 32'hDEAD_BEEF, '0);
    add_mem("mix_lb", OP_LOAD, MS_B, 32'h200, 32'd3, '0, 5'd13);
    add_alu("mix_xor", XOR, 1'b0, 32'hFFFF_FFFF, 32'h1);
    add_mem("mix_lhu", OP_LOAD, MS_HU, 32'h200, 32'd0, '0, 5'd14);
    add_alu("mix_sltu", SLTU, 1'b0, 32'd1, 32'd2);
  endtask

  task automatic drive(input entry_t e);
    pc = e.pc;
    opcode = e.opcode;
    funct = e.funct;
    rd = e.rd;
    src1 = e.src1;
    src2 = e.src2;
    imm = e.imm;
    csr = e.csr;
    alu_a = e.alu_a;
    alu_b = e.alu_b;
    alu_funct = e.alu_funct;
    alu_funcs = e.alu_funcs;
  endtask

  task automatic check_word(input string name, input logic [`XLEN_W-1:0] exp,
                            input logic [`XLEN_W-1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input logic [`REG_ADDR_W-1:0] exp_idx,
                           input logic [`XLEN_W-1:0] exp_data,
                           input logic [`REG_ADDR_W-1:0] act_idx,
                           input logic [`XLEN_W-1:0] act_data);
    if (act_idx !== exp_idx || act_data !== exp_data) begin
      err_cnt++;
      $display("ERR %s expected x%0d=%h actual x%0d=%h", name, exp_idx, exp_data,
               act_idx, act_data);
    end
  endtask

  task automatic check_csr(input string name, input logic [`CSR_ADDR_W-1:0] exp_addr,
                           input logic [`XLEN_W-1:0] exp_data,
                           input logic [`CSR_ADDR_W-1:0] act_addr,
                           input logic [`XLEN_W-1:0] act_data);
    if (act_addr !== exp_addr || act_data !== exp_data) begin
      err_cnt++;
      $display("ERR %s expected csr %h=%h actual csr %h=%h", name, exp_addr, exp_data,
               act_addr, act_data);
    end
  endtask

  task automatic expect_strobe(input string name, input string sig, input logic exp,
                               input logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("%s: %s was %s", name, sig, exp ? "missing" : "raised without cause");
    end
  endtask

  task automatic run_entry(input int i);
    entry_t e;
    string name;
    int errs0;
    int wen_cnt;
    e = table_q[i];
    name = name_q[i];
    errs0 = err_cnt;
    drive(e);
    id_valid = 1'b1;
    #1;
    check_word({name, " npc"}, e.exp_npc, npc);
    @(posedge clk); // id_ready is known high here
    @(negedge clk);
    id_valid = 1'b0;
    if (e.opcode == OP_LOAD || e.opcode == OP_STORE) begin
      wen_cnt = gpr_wen;
      if (id_ready) begin
        err_cnt++;
        $display("%s: id_ready stayed high during the memory access", name);
      end
      while (!id_ready) begin
        @(negedge clk);
        if (gpr_wen) begin
          wen_cnt++;
          check_reg(name, e.rd, e.exp_wdata, gpr_waddr, gpr_wdata);
        end
      end
      if (wen_cnt != int'(e.exp_wen)) begin
        err_cnt++;
        $display("%s: gpr_wen pulsed %0d times, expected %0d", name, wen_cnt, e.exp_wen);
      end
    end else begin
      expect_strobe(name, "gpr_wen", e.exp_wen, gpr_wen);
      if (e.exp_wen && gpr_wen) check_reg(name, e.rd, e.exp_wdata, gpr_waddr, gpr_wdata);
      expect_strobe(name, "csr_wen1", e.exp_csr1, csr_wen1);
      if (e.exp_csr1 && csr_wen1) begin
        check_csr(name, e.exp_csr1_addr, e.exp_csr1_data, csr_waddr1, csr_wdata1);
      end
      expect_strobe(name, "csr_wen2", e.exp_csr2, csr_wen2);
      if (e.exp_csr2 && csr_wen2) begin
        check_csr(name, `CSR_MCAUSE, `CAUSE_ECALL, csr_waddr2, csr_wdata2);
      end
      if (!id_ready) begin
        err_cnt++;
        $display("%s: id_ready dropped after a non-memory instruction", name);
      end
    end
    $display("test %-12s %s", name, (err_cnt == errs0) ? "ok" : "failed");
  endtask

  initial begin
    int gap;
    void'($urandom(11));
    rstn = 1'b1;
    id_valid = 1'b0;
    drive('0);
    build_table();
    timeout_cycles = table_q.size() * 10 + 50;
    repeat (4) @(negedge clk);
    rstn = 1'b0;
    for (int i = 0; i < table_q.size(); i++) begin
      gap = $urandom % 3; // idle cycles before the next instruction
      repeat (gap) @(negedge clk);
      run_entry(i);
    end
    $display("%0d tests, %0d errors, %0d assertion failures", table_q.size(), err_cnt,
             u_dut.u_exu.u_chk.fail_cnt);
    if (err_cnt == 0 && u_dut.u_exu.u_chk.fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- sim/exec_chk.sv
`timescale 1ns/100ps
`include "exec_defs.svh"

module exec_chk (
  input logic clk,
  input logic rstn,
  input logic id_valid,
  input logic id_ready,
  input logic gpr_wen,
  input logic csr_wen1,
  input logic csr_wen2,
  input logic rd_req_valid,
  input logic rd_req_ready,
  input logic [`XLEN_W-1:0] rd_addr,
  input logic wr_req_valid,
  input logic wr_req_ready,
  input logic [`XLEN_W-1:0] wr_addr
);
  int fail_cnt = 0; // failed assertions so far
  logic id_fire;

  assign id_fire = id_valid & id_ready;

  // a raised request only drops after a transfer
  a_rd_hold: assert property (@(posedge clk) disable iff (rstn)
    rd_req_valid |=> $past(rd_req_ready) || (rd_req_valid && $stable(rd_addr)))
    else begin
      fail_cnt++;
      $error("load request dropped or moved before ready");
    end

  a_wr_hold: assert property (@(posedge clk) disable iff (rstn)
    wr_req_valid |=> $past(wr_req_ready) || (wr_req_valid && $stable(wr_addr)))
    else begin
      fail_cnt++;
      $error("store request dropped or moved before ready");
    end

  // a second cycle of strobe needs a new instruction behind it
  a_gpr_pulse: assert property (@(posedge clk) disable iff (rstn)
    gpr_wen |=> !gpr_wen || $past(id_fire))
    else begin
      fail_cnt++;
      $error("gpr_wen held for two cycles by one instruction");
    end

  a_csr1_pulse: assert property (@(posedge clk) disable iff (rstn)
    csr_wen1 |=> !csr_wen1 || $past(id_fire))
    else begin
      fail_cnt++;
      $error("csr_wen1 held for two cycles by one instruction");
    end

  a_csr2_pulse: assert property (@(posedge clk) disable iff (rstn)
    csr_wen2 |=> !csr_wen2 || $past(id_fire))
    else begin
      fail_cnt++;
      $error("csr_wen2 held for two cycles by one instruction");
    end

  a_ready_after_reset: assert property (@(posedge clk) $fell(rstn) |-> id_ready)
    else begin
      fail_cnt++;
      $error("id_ready low in the first cycle after reset");
    end

endmodule

bind exu exec_chk u_chk (
  .clk(clk),
  .rstn(rstn),
  .id_valid(id_valid),
  .id_ready(id_ready),
  .gpr_wen(gpr_wen),
  .csr_wen1(csr_wen1),
  .csr_wen2(csr_wen2),
  .rd_req_valid(rd_ch.req_valid),
  .rd_req_ready(rd_ch.req_ready),
  .rd_addr(rd_ch.addr),
  .wr_req_valid(wr_ch.req_valid),
  .wr_req_ready(wr_ch.req_ready),
  .wr_addr(wr_ch.addr)
);

//--- rtl/exec_top.sv
`timescale 1ns/100ps
`include "exec_defs.svh"

module exec_top (
  input logic clk,
  input logic rstn,
  input logic id_valid,
  output logic id_ready,
  input logic [`XLEN_W-1:0] pc,
  input exec_pkg::opcode_e opcode,
  input logic [2:0] funct,
  input logic [`REG_ADDR_W-1:0] rd,
  input logic [`XLEN_W-1:0] src1,
  input logic [`XLEN_W-1:0] src2,
  input logic [`XLEN_W-1:0] imm,
  input logic [`XLEN_W-1:0] csr,
  input logic [`XLEN_W-1:0] alu_a,
  input logic [`XLEN_W-1:0] alu_b,
  input exec_pkg::alu_funct_e alu_funct,
  input logic alu_funcs,
  output logic [`XLEN_W-1:0] npc,
  output logic gpr_wen,
  output logic [`REG_ADDR_W-1:0] gpr_waddr,
  output logic [`XLEN_W-1:0] gpr_wdata,
  output logic csr_wen1,
  output logic [`CSR_ADDR_W-1:0] csr_waddr1,
  output logic [`XLEN_W-1:0] csr_wdata1,
  output logic csr_wen2,
  output logic [`CSR_ADDR_W-1:0] csr_waddr2,
  output logic [`XLEN_W-1:0] csr_wdata2
);

  mem_rd_if rd_ch ();
  mem_wr_if wr_ch ();

  exu u_exu (
    .clk(clk),
    .rstn(rstn),
    .id_valid(id_valid),
    .id_ready(id_ready),
    .pc(pc),
    .opcode(opcode),
    .funct(funct),
    .rd(rd),
    .src1(src1),
    .src2(src2),
    .imm(imm),
    .csr(csr),
    .alu_a(alu_a),
    .alu_b(alu_b),
    .alu_funct(alu_funct),
    .alu_funcs(alu_funcs),
    .npc(npc),
    .gpr_wen(gpr_wen),
    .gpr_waddr(gpr_waddr),
    .gpr_wdata(gpr_wdata),
    .csr_wen1(csr_wen1),
    .csr_waddr1(csr_waddr1),
    .csr_wdata1(csr_wdata1),
    .csr_wen2(csr_wen2),
    .csr_waddr2(csr_waddr2),
    .csr_wdata2(csr_wdata2),
    .rd_ch(rd_ch.requester),
    .wr_ch(wr_ch.requester)
  );

  data_mem u_dmem (
    .clk(clk),
    .rstn(rstn),
    .rd_ch(rd_ch.responder),
    .wr_ch(wr_ch.responder)
  );

endmodule

//--- rtl/data_mem.sv
`timescale 1ns/100ps
`include "exec_defs.svh"

module data_mem (
  input logic clk,
  input logic rstn,
  mem_rd_if.responder rd_ch,
  mem_wr_if.responder wr_ch
);
  import exec_pkg::*;

  localparam int IDX_W = $clog2(`DMEM_WORDS);
  localparam int LANES = `XLEN_W / 8;

  logic [`XLEN_W-1:0] mem [`DMEM_WORDS];
  logic pend_rd;
  logic pend_wr;
  logic idle;
  logic [`XLEN_W-1:0] req_addr;
  mem_size_e req_size;
  logic [`XLEN_W-1:0] req_wdata;
  logic [IDX_W-1:0] req_idx;
  logic [4:0] lane_sh;
  logic [`XLEN_W-1:0] word_sh;
  logic [`XLEN_W-1:0] load_val;
  logic [`XLEN_W-1:0] store_sh;
  logic [LANES-1:0] byte_en;

  // one transaction at a time across both channels
  assign idle = ~pend_rd & ~pend_wr & ~rd_ch.res_valid & ~wr_ch.res_valid;
  assign rd_ch.req_ready = idle;
  assign wr_ch.req_ready = idle & ~rd_ch.req_valid;

  assign req_idx = req_addr[IDX_W+1:2];
  assign lane_sh = {req_addr[1:0], 3'b000};
  assign word_sh = mem[req_idx] >> lane_sh;
  assign store_sh = req_wdata << lane_sh;

  always_comb begin
    case (req_size)
      MS_B:    load_val = {{(`XLEN_W-8){word_sh[7]}}, word_sh[7:0]};
      MS_H:    load_val = {{(`XLEN_W-16){word_sh[15]}}, word_sh[15:0]};
      MS_BU:   load_val = {{(`XLEN_W-8){1'b0}}, word_sh[7:0]};
      MS_HU:   load_val = {{(`XLEN_W-16){1'b0}}, word_sh[15:0]};
      default: load_val = word_sh;
    endcase
  end

  always_comb begin
    case (req_size)
      MS_B, MS_BU: byte_en = LANES'(4'b0001) << req_addr[1:0];
      MS_H, MS_HU: byte_en = LANES'(4'b0011) << req_addr[1:0];
      default:     byte_en = '1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      pend_rd <= 1'b0;
      pend_wr <= 1'b0;
      rd_ch.res_valid <= 1'b0;
      wr_ch.res_valid <= 1'b0;
    end else begin
      pend_rd <= rd_ch.req_valid & rd_ch.req_ready;
      pend_wr <= wr_ch.req_valid & wr_ch.req_ready;
      if (pend_rd) rd_ch.res_valid <= 1'b1;
      else if (rd_ch.res_ready) rd_ch.res_valid <= 1'b0; // held until taken
      if (pend_wr) wr_ch.res_valid <= 1'b1;
      else if (wr_ch.res_ready) wr_ch.res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_ch.req_valid & rd_ch.req_ready) begin
      req_addr <= rd_ch.addr;
      req_size <= rd_ch.size;
    end else if (wr_ch.req_valid & wr_ch.req_ready) begin
      req_addr <= wr_ch.addr;
      req_size <= wr_ch.size;
      req_wdata <= wr_ch.wdata;
    end
    if (pend_rd) rd_ch.rdata <= load_val;
    if (pend_wr) begin
      for (int i = 0; i < LANES; i++) begin
        if (byte_en[i]) mem[req_idx][8*i +: 8] <= store_sh[8*i +: 8];
      end
    end
  end

endmodule

//--- rtl/exu.sv
`timescale 1ns/100ps
`include "exec_defs.svh"

module exu (
  input logic clk,
  input logic rstn,
  input logic id_valid,
  output logic id_ready,
  input logic [`XLEN_W-1:0] pc,
  input exec_pkg::opcode_e opcode,
  input logic [2:0] funct,
  input logic [`REG_ADDR_W-1:0] rd,
  input logic [`XLEN_W-1:0] src1,
  input logic [`XLEN_W-1:0] src2,
  input logic [`XLEN_W-1:0] imm,
  input logic [`XLEN_W-1:0] csr,
  input logic [`XLEN_W-1:0] alu_a,
  input logic [`XLEN_W-1:0] alu_b,
  input exec_pkg::alu_funct_e alu_funct,
  input logic alu_funcs,
  output logic [`XLEN_W-1:0] npc,
  output logic gpr_wen,
  output logic [`REG_ADDR_W-1:0] gpr_waddr,
  output logic [`XLEN_W-1:0] gpr_wdata,
  output logic csr_wen1,
  output logic [`CSR_ADDR_W-1:0] csr_waddr1,
  output logic [`XLEN_W-1:0] csr_wdata1,
  output logic csr_wen2,
  output logic [`CSR_ADDR_W-1:0] csr_waddr2,
  output logic [`XLEN_W-1:0] csr_wdata2,
  mem_rd_if.requester rd_ch,
  mem_wr_if.requester wr_ch
);
  import exec_pkg::*;

  logic [`XLEN_W-1:0] alu_val;
  logic id_fire;
  logic is_load;
  logic is_store;
  logic wb_en;
  logic [`XLEN_W-1:0] wb_data;
  logic csr_op;
  logic ecall;
  logic [`REG_ADDR_W-1:0] ld_rd; // destination of the open load
  logic rd_req_fire;
  logic rd_res_fire;
  logic wr_req_fire;
  logic wr_res_fire;

  alu u_alu (
    .a(alu_a),
    .b(alu_b),
    .funct(alu_funct),
    .funcs(alu_funcs),
    .val(alu_val)
  );

  exu_next_pc u_next_pc (
    .pc(pc),
    .src1(src1),
    .imm(imm),
    .csr(csr),
    .opcode(opcode),
    .funct(funct),
    .alu_val(alu_val),
    .npc(npc)
  );

  assign id_fire = id_valid & id_ready;
  assign is_load = (opcode == OP_LOAD);
  assign is_store = (opcode == OP_STORE);
  assign rd_req_fire = rd_ch.req_valid & rd_ch.req_ready;
  assign rd_res_fire = rd_ch.res_valid & rd_ch.res_ready;
  assign wr_req_fire = wr_ch.req_valid & wr_ch.req_ready;
  assign wr_res_fire = wr_ch.res_valid & wr_ch.res_ready;

  // loads write back later from the response
  always_comb begin
    case (opcode)
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_CALRI, OP_CALRR: wb_en = 1'b1;
      OP_SYS:  wb_en = |funct; // csr ops read the old value
      default: wb_en = 1'b0;
    endcase
  end

  assign wb_data = (opcode == OP_SYS) ? csr : alu_val;

  assign csr_op = (opcode == OP_SYS) & (|funct);
  assign ecall = (opcode == OP_SYS) & (funct == 3'b000) & (imm[`CSR_ADDR_W-1:0] == '0);

  // mcause write is fixed
  assign csr_waddr2 = `CSR_MCAUSE;
  assign csr_wdata2 = `XLEN_W'(`CAUSE_ECALL);

  always_ff @(posedge clk) begin
    if (rstn) begin
      id_ready <= 1'b1;
      gpr_wen <= 1'b0;
      csr_wen1 <= 1'b0;
      csr_wen2 <= 1'b0;
      rd_ch.req_valid <= 1'b0;
      rd_ch.res_ready <= 1'b0;
      wr_ch.req_valid <= 1'b0;
      wr_ch.res_ready <= 1'b0;
    end else begin
      gpr_wen <= id_fire & wb_en; // single-cycle strobes
      csr_wen1 <= id_fire & (csr_op | ecall);
      csr_wen2 <= id_fire & ecall;
      if (id_fire & is_load) begin
        rd_ch.req_valid <= 1'b1;
        rd_ch.res_ready <= 1'b1;
        id_ready <= 1'b0;
      end
      if (id_fire & is_store) begin
        wr_ch.req_valid <= 1'b1;
        wr_ch.res_ready <= 1'b1;
        id_ready <= 1'b0;
      end
      if (rd_req_fire) rd_ch.req_valid <= 1'b0;
      if (wr_req_fire) wr_ch.req_valid <= 1'b0;
      if (rd_res_fire) begin
        rd_ch.res_ready <= 1'b0;
        gpr_wen <= 1'b1; // load result
        id_ready <= 1'b1;
      end
      if (wr_res_fire) begin
        wr_ch.res_ready <= 1'b0;
        id_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (id_fire) begin
      gpr_waddr <= rd;
      gpr_wdata <= wb_data;
      csr_waddr1 <= csr_op ? imm[`CSR_ADDR_W-1:0] : `CSR_MEPC; // ecall saves pc to mepc
      csr_wdata1 <= alu_val;
      ld_rd <= rd;
    end else if (rd_res_fire) begin
      gpr_waddr <= ld_rd;
      gpr_wdata <= rd_ch.rdata;
    end
    if (id_fire & is_load) begin
      rd_ch.addr <= alu_val;
      rd_ch.size <= mem_size_e'(funct);
    end
    if (id_fire & is_store) begin
      wr_ch.addr <= alu_val;
      wr_ch.size <= mem_size_e'(funct);
      wr_ch.wdata <= src2;
    end
  end

endmodule

//--- rtl/exu_next_pc.sv
`timescale 1ns/100ps
`include "exec_defs.svh"

module exu_next_pc (
  input logic [`XLEN_W-1:0] pc,
  input logic [`XLEN_W-1:0] src1,
  input logic [`XLEN_W-1:0] imm,
  input logic [`XLEN_W-1:0] csr,
  input exec_pkg::opcode_e opcode,
  input logic [2:0] funct,
  input logic [`XLEN_W-1:0] alu_val,
  output logic [`XLEN_W-1:0] npc
);
  import exec_pkg::*;

  logic alu_zero;
  logic br_taken; // only meaningful for OP_BRANCH
  logic [`XLEN_W-1:0] seq_pc;
  logic [`XLEN_W-1:0] target;

  assign alu_zero = ~|alu_val;
  assign seq_pc = pc + `XLEN_W'(4);

  // alu does sub for eq/ne and slt(u) for the rest
  always_comb begin
    case (branch_e'(funct))
      BR_BEQ:          br_taken = alu_zero;
      BR_BNE:          br_taken = ~alu_zero;
      BR_BLT, BR_BLTU: br_taken = alu_val[0];
      BR_BGE, BR_BGEU: br_taken = ~alu_val[0];
      default:         br_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      OP_JAL:    target = pc + imm;
      OP_JALR:   target = src1 + imm;
      OP_BRANCH: target = br_taken ? pc + imm : seq_pc;
      OP_SYS:    target = (funct == 3'b000) ? csr : seq_pc; // ecall / mret
      default:   target = seq_pc;
    endcase
  end

  assign npc = {target[`XLEN_W-1:1], 1'b0};

endmodule

//--- rtl/alu.sv
`timescale 1ns/100ps
`include "exec_defs.svh"

module alu (
  input logic [`XLEN_W-1:0] a,
  input logic [`XLEN_W-1:0] b,
  input exec_pkg::alu_funct_e funct,
  input logic funcs,
  output logic [`XLEN_W-1:0] val
);
  import exec_pkg::*;

  localparam int SH_W = $clog2(`XLEN_W);

  logic [SH_W-1:0] shamt;

  assign shamt = b[SH_W-1:0];

  always_comb begin
    case (funct)
      ADD:  val = funcs ? a - b : a + b;
      SLL:  val = a << shamt;
      SLT:  val = `XLEN_W'($signed(a) < $signed(b)); // 1 or 0 in bit 0
      SLTU: val = `XLEN_W'(a < b);
      XOR:  val = a ^ b;
      SR:   val = funcs ? `XLEN_W'($signed(a) >>> shamt) : a >> shamt;
      OR:   val = a | b;
      AND:  val = a & b;
      default: val = a + b;
    endcase
  end

endmodule

//--- rtl/mem_if.sv
`timescale 1ns/100ps
`include "exec_defs.svh"

// load channel
interface mem_rd_if;
  import exec_pkg::*;

  logic req_valid;
  logic req_ready;
  logic [`XLEN_W-1:0] addr;
  mem_size_e size;
  logic res_valid;
  logic res_ready;
  logic [`XLEN_W-1:0] rdata; // already sized and extended

  modport requester (output req_valid, addr, size, res_ready,
                     input req_ready, res_valid, rdata);
  modport responder (input req_valid, addr, size, res_ready,
                     output req_ready, res_valid, rdata);
endinterface

// store channel
interface mem_wr_if;
  import exec_pkg::*;

  logic req_valid;
  logic req_ready;
  logic [`XLEN_W-1:0] addr;
  mem_size_e size;
  logic [`XLEN_W-1:0] wdata; // lane 0 aligned
  logic res_valid;
  logic res_ready;

  modport requester (output req_valid, addr, size, wdata, res_ready,
                     input req_ready, res_valid);
  modport responder (input req_valid, addr, size, wdata, res_ready,
                     output req_ready, res_valid);
endinterface

//--- rtl/exec_pkg.sv
package exec_pkg;

  // opcode class, matches inst[6:2]
  typedef enum logic [4:0] {
    OP_LOAD   = 5'b00000,
    OP_CALRI  = 5'b00100,
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_CALRR  = 5'b01100,
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011,
    OP_SYS    = 5'b11100
  } opcode_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_e;

  // funcs picks sub on ADD and sra on SR
  typedef enum logic [2:0] {
    ADD  = 3'b000,
    SLL  = 3'b001,
    SLT  = 3'b010,
    SLTU = 3'b011,
    XOR  = 3'b100,
    SR   = 3'b101,
    OR   = 3'b110,
    AND  = 3'b111
  } alu_funct_e;

  typedef enum logic [2:0] {
    MS_B  = 3'b000,
    MS_H  = 3'b001,
    MS_W  = 3'b010,
    MS_BU = 3'b100,
    MS_HU = 3'b101
  } mem_size_e;

endpackage

//--- rtl/exec_defs.svh
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// datapath widths
`define XLEN_W 32
`define REG_ADDR_W 5
`define CSR_ADDR_W 12

// data memory depth in words
`define DMEM_WORDS 256

// machine trap csrs
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342

`define CAUSE_ECALL 11 // environment call from m-mode

`endif
